// ==== rtl/rq_cfg_pkg.sv ====
// ********************
// sizes shared by every queue in the scheduler
// usable capacity of a queue is DEPTH-1, one slot stays empty
// DEPTH must be a power of two so pointers wrap by overflow
// ********************
package rq_cfg_pkg;

    localparam int ADDR_W = 2;              // bus address width
    localparam int DEPTH  = 4;              // slots per queue
    localparam int PTR_W  = $clog2(DEPTH);  // head/tail pointer width

    typedef logic [ADDR_W-1:0] addr_t;      // one address word
    typedef logic [PTR_W-1:0]  ptr_t;       // queue pointer

    // whole storage image of one queue, slot i in [i]
    typedef logic [DEPTH-1:0][ADDR_W-1:0] entry_vec_t;

endpackage

// ==== rtl/rq_req_pkg.sv ====
// ********************
// request kinds and the issue record
// the issue record carries no tag or data, only the address
// ********************
package rq_req_pkg;

    // which queue a request is steered to
    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_kind_t;

    // arbiter to issue register, ADDR_W+2 bits
    typedef struct packed {
        logic              valid;    // something was chosen this cycle
        logic              is_read;  // 1 = read head, 0 = write head
        rq_cfg_pkg::addr_t addr;     // address of the chosen entry
    } issue_t;

endpackage

// ==== rtl/rq_queue_if.sv ====
// ********************
// boundary of one request queue
// push only when !full, pop only when !empty
// both are one-cycle strobes taken at the rising edge
// ********************
`timescale 1ns/1ps

interface rq_queue_if (
    input logic clkin   // only the consumer side samples it, for checks
);

    logic                         push;       // enqueue strobe
    rq_cfg_pkg::addr_t            push_addr;  // address to enqueue
    logic                         full;       // DEPTH-1 entries held
    logic                         pop;        // dequeue strobe
    logic                         empty;
    rq_cfg_pkg::addr_t            head_addr;  // oldest entry
    rq_cfg_pkg::entry_vec_t       entries;    // raw storage image
    logic [rq_cfg_pkg::DEPTH-1:0] pend_mask;  // slot occupied

    // the queue itself
    modport owner (
        input  push, push_addr, pop,
        output full, empty, head_addr, entries, pend_mask
    );

    // request steering side
    modport producer (
        output push, push_addr,
        input  full
    );

    // arbitration side, sees every pending slot for the hazard compare
    modport consumer (
        input  clkin,
        output pop,
        input  empty, head_addr, entries, pend_mask
    );

endinterface

// ==== rtl/req_decode.sv ====
// ********************
// grant register and request steering
// at most one request per cycle, read_in picks the queue
// a request hitting a full queue is lost, nothing tells the requester
// ********************
`timescale 1ns/1ps

module req_decode (
    input  logic              clkin,
    input  logic              reset,
    input  logic              valid_in,     // request strobe
    input  logic              read_in,      // 1 = read, 0 = write
    input  rq_cfg_pkg::addr_t addr_in,
    input  logic              bus_gnt_raw,  // unregistered bus grant
    output logic              gnt_q,        // grant, one cycle late
    rq_queue_if.producer      rd,
    rq_queue_if.producer      wr
);

    rq_req_pkg::req_kind_t kind;  // target queue of this cycle's request

    assign kind = read_in ? rq_req_pkg::REQ_READ : rq_req_pkg::REQ_WRITE;

    // grant is registered so issue happens on the edge after it is seen
    always_ff @(posedge clkin) begin
        if (reset) begin
            gnt_q <= 1'b0;
        end else begin
            gnt_q <= bus_gnt_raw;
        end
    end

    // steer, full queue drops the request
    assign rd.push = valid_in && (kind == rq_req_pkg::REQ_READ) && !rd.full;
    assign wr.push = valid_in && (kind == rq_req_pkg::REQ_WRITE) && !wr.full;

    // same address goes to both, only the strobe differs
    assign rd.push_addr = addr_in;
    assign wr.push_addr = addr_in;

    // one request per cycle lands in one queue at most
    a_one_push: assert property (
        @(posedge clkin) disable iff (reset)
        !(rd.push && wr.push)
    );

endmodule

// ==== rtl/req_fifo.sv ====
// ********************
// circular request buffer, DEPTH slots, DEPTH-1 usable
// full is tail+1 == head, empty is tail == head
// storage and pending mask are exported for the hazard compare
// push and pop in one cycle are both taken
// ********************
`timescale 1ns/1ps

module req_fifo (
    input  logic      clkin,
    input  logic      reset,
    rq_queue_if.owner q
);

    rq_cfg_pkg::entry_vec_t mem;   // slot storage
    rq_cfg_pkg::ptr_t       head;  // next entry out
    rq_cfg_pkg::ptr_t       tail;  // next free slot
    rq_cfg_pkg::ptr_t       fill;  // entries held, tail - head mod DEPTH

    assign fill = rq_cfg_pkg::ptr_t'(tail - head);

    always_ff @(posedge clkin) begin
        if (reset) begin
            mem  <= '0;
            head <= '0;
            tail <= '0;
        end else begin
            if (q.push) begin
                mem[tail] <= q.push_addr;
                tail      <= rq_cfg_pkg::ptr_t'(tail + 1'b1);  // wraps at DEPTH
            end
            if (q.pop) begin
                head <= rq_cfg_pkg::ptr_t'(head + 1'b1);
            end
        end
    end

    assign q.empty     = (tail == head);
    assign q.full      = (rq_cfg_pkg::ptr_t'(tail + 1'b1) == head);  // one slot kept free
    assign q.head_addr = mem[head];
    assign q.entries   = mem;

    // slot i is pending when its distance from head is below the fill level
    // this covers the wrapped case without a separate branch
    always_comb begin
        for (int i = 0; i < rq_cfg_pkg::DEPTH; i++) begin
            q.pend_mask[i] = rq_cfg_pkg::ptr_t'(rq_cfg_pkg::ptr_t'(i) - head) < fill;
        end
    end

    // producer must respect full
    a_no_push_full: assert property (
        @(posedge clkin) disable iff (reset)
        !(q.push && q.full)
    );

    // consumer must respect empty
    a_no_pop_empty: assert property (
        @(posedge clkin) disable iff (reset)
        !(q.pop && q.empty)
    );

    // a lone push shows up as one more pending slot on the next cycle
    a_push_grows: assert property (
        @(posedge clkin) disable iff (reset)
        (q.push && !q.pop) |=> ($countones(q.pend_mask) == $past($countones(q.pend_mask)) + 1)
    );

endmodule

// ==== rtl/hazard_arbiter.sv ====
// ********************
// picks what goes on the bus at the next granted edge
// reads win unless the read head matches a pending write
// the match is taken from current queue state, no lag
// pops only when gnt_q is high
// ********************
`timescale 1ns/1ps

module hazard_arbiter (
    input  logic               gnt_q,     // registered grant
    rq_queue_if.consumer       rd,
    rq_queue_if.consumer       wr,
    output rq_req_pkg::issue_t issue,     // chosen record
    output logic               issue_en   // load strobe for the issue register
);

    logic [rq_cfg_pkg::DEPTH-1:0] hit_vec;  // pending write slots equal to read head
    logic                         match;    // read head must wait

    // compare read head against every occupied write slot
    always_comb begin
        for (int i = 0; i < rq_cfg_pkg::DEPTH; i++) begin
            hit_vec[i] = wr.pend_mask[i] && (wr.entries[i] == rd.head_addr);
        end
    end

    assign match = !rd.empty && (|hit_vec);

    always_comb begin
        issue  = '0;    // idle record, valid low
        rd.pop = 1'b0;
        wr.pop = 1'b0;
        if (!rd.empty && !match) begin
            issue.valid   = 1'b1;
            issue.is_read = 1'b1;
            issue.addr    = rd.head_addr;
            rd.pop        = gnt_q;
        end else if (!wr.empty) begin
            // also the hazard case, writes drain until the match clears
            issue.valid   = 1'b1;
            issue.is_read = 1'b0;
            issue.addr    = wr.head_addr;
            wr.pop        = gnt_q;
        end
    end

    assign issue_en = gnt_q;  // record is loaded on every granted edge

    // a read only leaves while no pending write shares its address
    a_read_no_hazard: assert property (
        @(posedge rd.clkin)
        rd.pop |-> (hit_vec == '0)
    );

    // queues only move on a grant, and never both at once
    a_pop_needs_gnt: assert property (
        @(posedge rd.clkin)
        (rd.pop || wr.pop) |-> (gnt_q && !(rd.pop && wr.pop))
    );

    // a held read always has a write to drain, so no deadlock
    a_hazard_drains: assert property (
        @(posedge rd.clkin)
        (match && gnt_q) |-> wr.pop
    );

endmodule

// ==== rtl/issue_reg.sv ====
// ********************
// registered bus outputs
// updated only on granted cycles, held otherwise
// an idle grant clears valid but keeps the last address and kind
// ********************
`timescale 1ns/1ps

module issue_reg (
    input  logic               clkin,
    input  logic               reset,
    input  logic               issue_en,  // granted cycle
    input  rq_req_pkg::issue_t issue,
    output logic               valid_out,
    output logic               is_read_out,
    output rq_cfg_pkg::addr_t  addr_out
);

    always_ff @(posedge clkin) begin
        if (reset) begin
            valid_out   <= 1'b0;
            is_read_out <= 1'b0;
            addr_out    <= '0;
        end else if (issue_en) begin
            valid_out <= issue.valid;
            if (issue.valid) begin   // nothing chosen, last address stays
                is_read_out <= issue.is_read;
                addr_out    <= issue.addr;
            end
        end
    end

    // outputs hold across ungranted cycles
    a_hold_no_gnt: assert property (
        @(posedge clkin) disable iff (reset)
        !issue_en |=> ($stable(addr_out) && $stable(is_read_out) && $stable(valid_out))
    );

endmodule

// ==== rtl/req_sched_top.sv ====
// ********************
// memory request scheduler, read and write queues
// one request per cycle in, one issue per granted cycle out
// requests to a full queue are dropped silently
// outputs move on the edge after bus_gnt_raw is seen high
// ********************
`timescale 1ns/1ps

module req_sched_top (
    input  logic              clkin,
    input  logic              reset,
    input  logic              valid_in,
    input  logic              read_in,
    input  rq_cfg_pkg::addr_t addr_in,
    input  logic              bus_gnt_raw,
    output logic              valid_out,
    output logic              is_read_out,
    output rq_cfg_pkg::addr_t addr_out,
    output rq_cfg_pkg::addr_t read_head_entry  // read queue slot at head, combinational
);

    logic               gnt_q;     // registered grant
    rq_req_pkg::issue_t issue;     // arbiter choice
    logic               issue_en;

    rq_queue_if rd_q (.clkin(clkin));  // read requests
    rq_queue_if wr_q (.clkin(clkin));  // write requests

    req_decode u_decode (
        .clkin       (clkin),
        .reset       (reset),
        .valid_in    (valid_in),
        .read_in     (read_in),
        .addr_in     (addr_in),
        .bus_gnt_raw (bus_gnt_raw),
        .gnt_q       (gnt_q),
        .rd          (rd_q.producer),
        .wr          (wr_q.producer)
    );

    req_fifo rd_fifo (.clkin(clkin), .reset(reset), .q(rd_q.owner));
    req_fifo wr_fifo (.clkin(clkin), .reset(reset), .q(wr_q.owner));

    hazard_arbiter u_arbiter (
        .gnt_q    (gnt_q),
        .rd       (rd_q.consumer),
        .wr       (wr_q.consumer),
        .issue    (issue),
        .issue_en (issue_en)
    );

    issue_reg u_issue (
        .clkin       (clkin),
        .reset       (reset),
        .issue_en    (issue_en),
        .issue       (issue),
        .valid_out   (valid_out),
        .is_read_out (is_read_out),
        .addr_out    (addr_out)
    );

    assign read_head_entry = rd_q.head_addr;

endmodule

// ==== dv/clk_gen.sv ====
// ********************
// testbench clock and reset source
// 4 ns period, reset high for 3 rising edges
// reset drops on a falling edge
// ********************
`timescale 1ns/1ps

module clk_gen (
    output logic clkin,
    output logic reset
);

    localparam int HALF_PERIOD = 2;  // ns

    initial begin
        clkin = 1'b0;
        forever #HALF_PERIOD clkin = ~clkin;
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clkin);
        @(negedge clkin);          // release away from the sampling edge
        reset = 1'b0;
    end

endmodule

// ==== dv/req_sched_tb.sv ====
// ********************
// random traffic for the request scheduler, checked against a queue model
// inputs change on the falling edge, outputs compared on the next falling edge
// grant rate changes per phase so queues fill and drain
// stops at the first mismatch
// ********************
`timescale 1ns/1ps

module req_sched_tb;

    localparam int NUM_CYCLES    = 2000;
    localparam int PHASE_LEN     = 100;  // cycles per grant-rate phase
    localparam int CLK_PERIOD_NS = 4;
    localparam int TIMEOUT_NS    = (NUM_CYCLES + 3 + 50) * CLK_PERIOD_NS;
    localparam int CAPACITY      = rq_cfg_pkg::DEPTH - 1;  // usable slots per queue

    logic              clkin;
    logic              reset;
    logic              valid_in;
    logic              read_in;
    rq_cfg_pkg::addr_t addr_in;
    logic              bus_gnt_raw;
    logic              valid_out;
    logic              is_read_out;
    rq_cfg_pkg::addr_t addr_out;
    rq_cfg_pkg::addr_t read_head_entry;

    // model state
    rq_cfg_pkg::addr_t rd_mem [rq_cfg_pkg::DEPTH];
    rq_cfg_pkg::addr_t wr_mem [rq_cfg_pkg::DEPTH];
    rq_cfg_pkg::ptr_t  rd_head;
    rq_cfg_pkg::ptr_t  wr_head;
    int                rd_cnt;       // entries held
    int                wr_cnt;
    logic              m_gnt;        // grant seen at the last edge
    logic              m_valid;
    logic              m_is_read;
    rq_cfg_pkg::addr_t m_addr;

    int hazard_holds;   // granted edges where a read waited on a write
    int drops;
    int reads_issued;
    int gnt_pct;        // grant probability of the current phase
    int pct_table [4] = '{0, 25, 60, 100};  // 0 starves the bus

    clk_gen u_clk (.clkin(clkin), .reset(reset));

    req_sched_top UUT (
        .clkin           (clkin),
        .reset           (reset),
        .valid_in        (valid_in),
        .read_in         (read_in),
        .addr_in         (addr_in),
        .bus_gnt_raw     (bus_gnt_raw),
        .valid_out       (valid_out),
        .is_read_out     (is_read_out),
        .addr_out        (addr_out),
        .read_head_entry (read_head_entry)
    );

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Fail at %0t ns: %s expected %0d actual %0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < rq_cfg_pkg::DEPTH; i++) begin
            rd_mem[i] = '0;
            wr_mem[i] = '0;
        end
        rd_head   = '0;
        wr_head   = '0;
        rd_cnt    = 0;
        wr_cnt    = 0;
        m_gnt     = 1'b0;
        m_valid   = 1'b0;
        m_is_read = 1'b0;
        m_addr    = '0;
    endtask

    // one rising edge, everything decided from the state before it
    task automatic step_model();
        logic             match;
        logic             pop_rd;
        logic             pop_wr;
        rq_cfg_pkg::ptr_t slot;
        match  = 1'b0;
        pop_rd = 1'b0;
        pop_wr = 1'b0;
        for (int k = 0; k < wr_cnt; k++) begin    // walk pending writes oldest first
            slot = rq_cfg_pkg::ptr_t'(int'(wr_head) + k);
            if (rd_cnt != 0 && wr_mem[slot] == rd_mem[rd_head]) match = 1'b1;
        end
        if (m_gnt) begin
            if (rd_cnt != 0 && !match) begin
                m_valid   = 1'b1;
                m_is_read = 1'b1;
                m_addr    = rd_mem[rd_head];
                pop_rd    = 1'b1;
                reads_issued++;
            end else if (wr_cnt != 0) begin
                m_valid   = 1'b1;
                m_is_read = 1'b0;
                m_addr    = wr_mem[wr_head];
                pop_wr    = 1'b1;
                if (match) hazard_holds++;
            end else begin
                m_valid = 1'b0;   // kind and address stay from the last issue
            end
        end
        if (valid_in) begin   // push against the fill level before the edge
            if (read_in) begin
                if (rd_cnt == CAPACITY) drops++;
                else begin
                    rd_mem[rq_cfg_pkg::ptr_t'(int'(rd_head) + rd_cnt)] = addr_in;
                    rd_cnt++;
                end
            end else begin
                if (wr_cnt == CAPACITY) drops++;
                else begin
                    wr_mem[rq_cfg_pkg::ptr_t'(int'(wr_head) + wr_cnt)] = addr_in;
                    wr_cnt++;
                end
            end
        end
        if (pop_rd) begin
            rd_head = rq_cfg_pkg::ptr_t'(rd_head + 1);
            rd_cnt--;
        end
        if (pop_wr) begin
            wr_head = rq_cfg_pkg::ptr_t'(wr_head + 1);
            wr_cnt--;
        end
        m_gnt = bus_gnt_raw;  // grant register
    endtask

    task automatic check_outputs();
        check_value("valid_out", int'(m_valid), int'(valid_out));
        check_value("is_read_out", int'(m_is_read), int'(is_read_out));
        check_value("addr_out", int'(m_addr), int'(addr_out));
        check_value("read_head_entry", int'(rd_mem[rd_head]), int'(read_head_entry));
    endtask

    task automatic drive_inputs();
        valid_in    = ($urandom_range(99, 0) < 70);
        read_in     = ($urandom_range(1, 0) == 1);
        addr_in     = rq_cfg_pkg::addr_t'($urandom());  // 2 bits, so hazards are common
        bus_gnt_raw = ($urandom_range(99, 0) < gnt_pct);
    endtask

    initial begin
        void'($urandom(32'hba93));
        valid_in     = 1'b0;
        read_in      = 1'b0;
        addr_in      = '0;
        bus_gnt_raw  = 1'b0;
        hazard_holds = 0;
        drops        = 0;
        reads_issued = 0;
        gnt_pct      = 0;
        model_reset();
        @(negedge reset);          // lands on a falling clock edge
        check_outputs();           // reset values
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            if (cyc % PHASE_LEN == 0) gnt_pct = pct_table[2'($urandom_range(3, 0))];
            drive_inputs();
            @(posedge clkin);
            step_model();
            @(negedge clkin);
            check_outputs();
        end
        $display("reads issued %0d, hazard holds %0d, drops %0d",
                 reads_issued, hazard_holds, drops);
        if (hazard_holds == 0 || drops == 0 || reads_issued == 0) begin
            $display("random traffic never hit a hazard hold, a full drop or a read issue");
            abort_run();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("run did not complete within %0d ns", TIMEOUT_NS);
        abort_run();
    end

endmodule

// ==== build.f ====
rtl/rq_cfg_pkg.sv
rtl/rq_req_pkg.sv
rtl/rq_queue_if.sv
rtl/req_decode.sv
rtl/req_fifo.sv
rtl/hazard_arbiter.sv
rtl/issue_reg.sv
rtl/req_sched_top.sv
dv/clk_gen.sv
dv/req_sched_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the request scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module req_sched_tb -f build.f

out=$(./obj_dir/Vreq_sched_tb) || true
printf '%s\n' "$out"

# exit status follows the pass line
printf '%s\n' "$out" | grep -qx "Verification passed"
